// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;  // boot address

    // inst[31:15] match values; 3R forms use all 17 bits
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_nor   = 17'h00028;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;
    localparam logic [16:0] op_sll_w = 17'h0002e;
    localparam logic [16:0] op_srl_w = 17'h0002f;
    localparam logic [16:0] op_sra_w = 17'h00030;
    // 2RI12 forms, opcode in inst[31:22], low 7 bits zero
    localparam logic [16:0] op_addi_w  = 17'b0000001010_0000000;
    localparam logic [16:0] op_andi    = 17'b0000001101_0000000;
    localparam logic [16:0] op_ori     = 17'b0000001110_0000000;
    localparam logic [16:0] op_xori    = 17'b0000001111_0000000;
    // 1RI20 form, opcode in inst[31:25]
    localparam logic [16:0] op_lu12i_w = 17'b0001010_0000000000;

    typedef enum logic [4:0] {
        alu_nop,
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_addi, alu_andi, alu_ori, alu_xori, alu_lu12i
    } alu_op_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_t               op;
        logic [xlen-1:0]       a;   // rj value
        logic [xlen-1:0]       b;   // rk value or immediate
        logic [reg_addr_w-1:0] rd;
        logic                  we;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = cpu_pkg::reset_pc
) (
    input  logic                     cpu_clk,
    input  logic                     cpu_rstn,
    input  logic                     ifetch_valid,
    input  logic [cpu_pkg::xlen-1:0] ifetch_inst,
    output logic                     ifetch_rreq,
    output logic [cpu_pkg::xlen-1:0] ifetch_addr,
    output logic                     id_valid,
    output logic [cpu_pkg::xlen-1:0] id_pc,
    output logic [cpu_pkg::xlen-1:0] id_inst
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc_q;
    logic            req_q;
    logic            accept;  // word handed over this edge

    assign ifetch_rreq = req_q;
    assign ifetch_addr = pc_q;  // held until the word is taken
    assign accept      = req_q & ifetch_valid;

    // request goes up the first edge after reset, nothing stalls it later
    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            req_q    <= 1'b0;
            pc_q     <= reset_pc;
            id_valid <= 1'b0;
        end else begin
            req_q    <= 1'b1;
            id_valid <= accept;            // bubble when no word came back
            if (accept) pc_q <= pc_q + 32'd4;
        end
    end

    // decode payload, loaded only with a real word
    always_ff @(posedge cpu_clk) begin
        if (accept) begin
            id_pc   <= pc_q;
            id_inst <= ifetch_inst;
        end
    end

endmodule

`default_nettype wire

// File: logic/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  logic [cpu_pkg::xlen-1:0]       inst,
    output cpu_pkg::alu_op_t               alu_op,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2,
    output logic [cpu_pkg::reg_addr_w-1:0] rd,
    output logic                           rf_we,
    output logic                           use_imm,
    output logic [cpu_pkg::xlen-1:0]       imm
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {imm_none, imm_si12, imm_ui12, imm_si20} imm_sel_t;

    logic [16:0] opc_r;    // 3R opcode field
    logic [16:0] opc_i12;  // 2RI12, immediate bits masked off
    logic [16:0] opc_i20;  // 1RI20
    imm_sel_t    imm_sel;

    assign opc_r   = inst[31:15];
    assign opc_i12 = {inst[31:22], 7'd0};
    assign opc_i20 = {inst[31:25], 10'd0};

    assign rd  = inst[4:0];
    assign rs1 = inst[9:5];    // rj
    assign rs2 = inst[14:10];  // rk

    always_comb begin
        alu_op  = alu_nop;
        use_imm = 1'b0;
        imm_sel = imm_none;
        case (opc_r)
            op_add_w: alu_op = alu_add;
            op_sub_w: alu_op = alu_sub;
            op_slt:   alu_op = alu_slt;
            op_sltu:  alu_op = alu_sltu;
            op_and:   alu_op = alu_and;
            op_or:    alu_op = alu_or;
            op_xor:   alu_op = alu_xor;
            op_nor:   alu_op = alu_nor;
            op_sll_w: alu_op = alu_sll;
            op_srl_w: alu_op = alu_srl;
            op_sra_w: alu_op = alu_sra;
            default:  ;  // not a kept 3R form
        endcase
        // immediate forms never alias a 3R pattern
        case (opc_i12)
            op_addi_w: begin
                alu_op  = alu_addi;
                use_imm = 1'b1;
                imm_sel = imm_si12;
            end
            op_andi, op_ori, op_xori: begin
                alu_op  = (opc_i12 == op_andi) ? alu_andi :
                          (opc_i12 == op_ori)  ? alu_ori  : alu_xori;
                use_imm = 1'b1;
                imm_sel = imm_ui12;  // logic ops zero-extend
            end
            default: ;
        endcase
        if (opc_i20 == op_lu12i_w) begin
            alu_op  = alu_lu12i;
            use_imm = 1'b1;
            imm_sel = imm_si20;
        end
        rf_we = (alu_op != alu_nop) && (rd != '0);  // r0 and unknown words write nothing
    end

    always_comb begin
        case (imm_sel)
            imm_si12: imm = {{20{inst[21]}}, inst[21:10]};
            imm_ui12: imm = {20'd0, inst[21:10]};
            imm_si20: imm = {inst[24:5], 12'd0};  // upper 20 bits
            default:  imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           cpu_clk,
    input  logic                           cpu_rstn,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
    output logic [cpu_pkg::xlen-1:0]       rd1,
    output logic [cpu_pkg::xlen-1:0]       rd2,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wr,
    input  logic [cpu_pkg::xlen-1:0]       wd
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

    // architectural state starts cleared
    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) regs[i] <= '0;
        end else if (we && wr != '0) begin
            regs[wr] <= wd;  // r0 stays zero
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: logic/forward_unit.sv
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
    input  logic [cpu_pkg::xlen-1:0]       rf_rd1,
    input  logic [cpu_pkg::xlen-1:0]       rf_rd2,
    input  logic                           ex_we,   // already qualified by ex valid
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_wr,
    input  logic [cpu_pkg::xlen-1:0]       ex_wd,
    input  logic                           wb_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_wr,
    input  logic [cpu_pkg::xlen-1:0]       wb_wd,
    output logic [cpu_pkg::xlen-1:0]       src1,
    output logic [cpu_pkg::xlen-1:0]       src2
);

    logic ex_hit1, ex_hit2;
    logic wb_hit1, wb_hit2;

    // r0 never forwards
    assign ex_hit1 = ex_we && (ex_wr == rs1) && (rs1 != '0);
    assign ex_hit2 = ex_we && (ex_wr == rs2) && (rs2 != '0);
    assign wb_hit1 = wb_we && (wb_wr == rs1) && (rs1 != '0);
    assign wb_hit2 = wb_we && (wb_wr == rs2) && (rs2 != '0);

    // execute is younger than write-back, so it wins
    assign src1 = ex_hit1 ? ex_wd : wb_hit1 ? wb_wd : rf_rd1;
    assign src2 = ex_hit2 ? ex_wd : wb_hit2 ? wb_wd : rf_rd2;

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t         op,
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    output logic [cpu_pkg::xlen-1:0] result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // .w shifts use 5 bits only

    always_comb begin
        case (op)
            alu_add, alu_addi: result = a + b;
            alu_sub:           result = a - b;
            alu_slt:           result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:          result = {{(xlen-1){1'b0}}, a < b};
            alu_and, alu_andi: result = a & b;
            alu_or,  alu_ori:  result = a | b;
            alu_xor, alu_xori: result = a ^ b;
            alu_nor:           result = ~(a | b);
            alu_sll:           result = a << shamt;
            alu_srl:           result = a >> shamt;
            alu_sra:           result = $unsigned($signed(a) >>> shamt);  // sign fill
            alu_lu12i:         result = b;  // immediate already shifted
            default:           result = '0;  // nop
        endcase
    end

endmodule

`default_nettype wire

// File: logic/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     cpu_clk,
    input  logic     cpu_rstn,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) out_valid <= 1'b0;
        else           out_valid <= in_valid;  // bubbles pass as valid low
    end

    // payload holds through bubbles
    always_ff @(posedge cpu_clk) begin
        if (in_valid) out_data <= in_data;
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = cpu_pkg::reset_pc
) (
    input  logic                           cpu_clk,
    input  logic                           cpu_rstn,
    // instruction fetch
    output logic                           ifetch_rreq,
    output logic [cpu_pkg::xlen-1:0]       ifetch_addr,
    input  logic                           ifetch_valid,
    input  logic [cpu_pkg::xlen-1:0]       ifetch_inst,
    // write-back trace
    output logic                           debug_wb_valid,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_ena,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_reg,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_value
);
    import cpu_pkg::*;

    // decode
    logic                  id_valid;
    logic [xlen-1:0]       id_pc, id_inst;
    alu_op_t               dec_op;
    logic [reg_addr_w-1:0] dec_rs1, dec_rs2, dec_rd;
    logic                  dec_we, dec_use_imm;
    logic [xlen-1:0]       dec_imm;
    logic [xlen-1:0]       rf_rd1, rf_rd2;
    logic [xlen-1:0]       src1, src2;
    id_ex_t                id_data;
    // execute
    logic                  ex_valid, ex_we;
    id_ex_t                ex_data;
    logic [xlen-1:0]       ex_result;
    ex_wb_t                ex_out;
    // write-back
    logic                  wb_valid, wb_we;
    ex_wb_t                wb_data;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .cpu_clk      (cpu_clk),
        .cpu_rstn     (cpu_rstn),
        .ifetch_valid (ifetch_valid),
        .ifetch_inst  (ifetch_inst),
        .ifetch_rreq  (ifetch_rreq),
        .ifetch_addr  (ifetch_addr),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_inst      (id_inst)
    );

    decoder u_decoder (
        .inst    (id_inst),
        .alu_op  (dec_op),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (dec_rd),
        .rf_we   (dec_we),
        .use_imm (dec_use_imm),
        .imm     (dec_imm)
    );

    reg_file u_rf (
        .cpu_clk  (cpu_clk),
        .cpu_rstn (cpu_rstn),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd1      (rf_rd1),
        .rd2      (rf_rd2),
        .we       (wb_we),
        .wr       (wb_data.rd),
        .wd       (wb_data.result)
    );

    forward_unit u_fwd (
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .rf_rd1 (rf_rd1),
        .rf_rd2 (rf_rd2),
        .ex_we  (ex_we),
        .ex_wr  (ex_data.rd),
        .ex_wd  (ex_result),
        .wb_we  (wb_we),
        .wb_wr  (wb_data.rd),
        .wb_wd  (wb_data.result),
        .src1   (src1),
        .src2   (src2)
    );

    // operand b picked in decode so execute sees plain values
    assign id_data = '{pc: id_pc, op: dec_op, a: src1,
                       b: dec_use_imm ? dec_imm : src2, rd: dec_rd, we: dec_we};

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .cpu_clk   (cpu_clk),
        .cpu_rstn  (cpu_rstn),
        .in_valid  (id_valid),
        .in_data   (id_data),
        .out_valid (ex_valid),
        .out_data  (ex_data)
    );

    alu u_alu (
        .op     (ex_data.op),
        .a      (ex_data.a),
        .b      (ex_data.b),
        .result (ex_result)
    );

    assign ex_we  = ex_valid & ex_data.we;  // stale payload must not forward
    assign ex_out = '{pc: ex_data.pc, result: ex_result, rd: ex_data.rd, we: ex_data.we};

    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .cpu_clk   (cpu_clk),
        .cpu_rstn  (cpu_rstn),
        .in_valid  (ex_valid),
        .in_data   (ex_out),
        .out_valid (wb_valid),
        .out_data  (wb_data)
    );

    assign wb_we = wb_valid & wb_data.we;

    // one pulse per retired word, nops retire with ena low
    assign debug_wb_valid = wb_valid;
    assign debug_wb_pc    = wb_data.pc;
    assign debug_wb_ena   = {4{wb_we}};
    assign debug_wb_reg   = wb_data.rd;
    assign debug_wb_value = wb_data.result;

endmodule

`default_nettype wire

// File: verif/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic cpu_clk,
    output logic cpu_rstn
);

    initial begin
        cpu_clk  = 1'b0;
        cpu_rstn = 1'b0;
        repeat (16) @(posedge cpu_clk);  // 16 cycles in reset
        @(negedge cpu_clk);
        cpu_rstn = 1'b1;  // release away from the rising edge
    end

    always #2 cpu_clk = ~cpu_clk;  // 4 ns period

endmodule

`default_nettype wire

// File: verif/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

    localparam logic [31:0] boot_pc = 32'h1c00_0000;
    localparam int          clk_ns  = 4;
    localparam int          rst_cyc = 16;

    logic        cpu_clk, cpu_rstn;
    logic        ifetch_rreq, ifetch_valid;
    logic [31:0] ifetch_addr, ifetch_inst;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc, debug_wb_value;
    logic [3:0]  debug_wb_ena;
    logic [4:0]  debug_wb_reg;

    logic [31:0] tdata [0:255];  // counts, program words, then expected triples
    int          prog_len, num_checks;
    int          checked, passed, errors;
    integer      seed;
    bit          ok;

    clk_gen u_clk (.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn));

    cpu_core #(.reset_pc(boot_pc)) uut (
        .cpu_clk        (cpu_clk),
        .cpu_rstn       (cpu_rstn),
        .ifetch_rreq    (ifetch_rreq),
        .ifetch_addr    (ifetch_addr),
        .ifetch_valid   (ifetch_valid),
        .ifetch_inst    (ifetch_inst),
        .debug_wb_valid (debug_wb_valid),
        .debug_wb_pc    (debug_wb_pc),
        .debug_wb_ena   (debug_wb_ena),
        .debug_wb_reg   (debug_wb_reg),
        .debug_wb_value (debug_wb_value)
    );

    function automatic logic [31:0] data_word(input int i);
        return tdata[i[7:0]];
    endfunction

    // instruction memory, anything outside the program reads as 0 (a nop)
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - boot_pc) >> 2;
        if (addr[1:0] != 2'b00 || idx >= prog_len) return 32'h0;
        return data_word(2 + int'(idx));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout bit match);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
            errors++;
            match = 1'b0;
        end
    endtask

    task automatic check_writeback();
        bit good;
        int base;
        good = 1'b1;
        if (checked >= num_checks) begin
            $display("unexpected write-back to r%0d at pc %08h", debug_wb_reg, debug_wb_pc);
            errors++;
            return;
        end
        base = 2 + prog_len + 3 * checked;  // pc, reg, value
        check_value("debug_wb_pc", debug_wb_pc, data_word(base), good);
        check_value("debug_wb_reg", 32'(debug_wb_reg), data_word(base + 1), good);
        check_value("debug_wb_value", debug_wb_value, data_word(base + 2), good);
        check_value("debug_wb_ena", 32'(debug_wb_ena), 32'hf, good);
        checked++;
        if (good) passed++;
        $display("wb %0d: pc %08h r%0d = %08h %s", checked, debug_wb_pc, debug_wb_reg,
                 debug_wb_value, good ? "ok" : "FAILED");
    endtask

    // fetch side, about 70 % of cycles return a word
    always @(negedge cpu_clk) begin
        ifetch_valid <= ($unsigned($random(seed)) % 100) < 70;
        ifetch_inst  <= fetch_word(ifetch_addr);  // addr holds until taken
    end

    // mid-cycle, debug outputs settled; nops and r0 writes carry ena low
    always @(negedge cpu_clk) begin
        if (cpu_rstn && debug_wb_valid && debug_wb_ena != 4'h0) check_writeback();
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = (rst_cyc + 8 * prog_len) * clk_ns;  // 8 cycles per word plus reset
        #(limit);
        $display("timeout: retirement stalled with %0d of %0d write-backs checked",
                 checked, num_checks);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        seed         = 97;
        ifetch_valid = 1'b0;
        ifetch_inst  = 32'h0;
        checked      = 0;
        passed       = 0;
        errors       = 0;
        $readmemh("verif/cpu_testdata.hex", tdata);
        prog_len   = tdata[0];
        num_checks = tdata[1];
        if (prog_len <= 0 || num_checks <= 0) begin
            $display("test data file missing or empty");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            @(posedge cpu_rstn);  // state still as reset left it
            ok = 1'b1;
            check_value("ifetch_addr", ifetch_addr, boot_pc, ok);
            check_value("ifetch_rreq", 32'(ifetch_rreq), 32'h0, ok);
            check_value("debug_wb_valid", 32'(debug_wb_valid), 32'h0, ok);
            $display("reset: ifetch_addr %08h %s", ifetch_addr, ok ? "ok" : "FAILED");
            wait (checked == num_checks);
            repeat (8) @(posedge cpu_clk);  // stray writes would show up here
            $display("done: %0d of %0d write-backs passed, %0d errors",
                     passed, num_checks, errors);
            if (errors == 0 && passed == num_checks) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/cpu_testdata.hex
// line 1: program word count, expected write-back count
// then program words from 1c000000, then one "pc reg value" triple per write-back
00000013 00000012
15000001 // lu12i.w r1, 0x80000
02bfec02 // addi.w  r2, r0, -5
02803043 // addi.w  r3, r2, 12   r2 from execute
00100864 // add.w   r4, r3, r2
00110c45 // sub.w   r5, r2, r3
00120c46 // slt     r6, r2, r3   signed
00128c47 // sltu    r7, r2, r3   unsigned
00180c28 // sra.w   r8, r1, r3
00178c29 // srl.w   r9, r1, r3
00170c6a // sll.w   r10, r3, r3
0014944b // and     r11, r2, r5
00150c8c // or      r12, r4, r3
00158c4d // xor     r13, r2, r3
0014008e // nor     r14, r4, r0
037c3c4f // andi    r15, r2, 0xf0f
03a00010 // ori     r16, r0, 0x800  zero extended
03fffe11 // xori    r17, r16, 0xfff
00100820 // add.w   r0, r1, r2   no write-back
00104412 // add.w   r18, r0, r17
1c000000 01 80000000
1c000004 02 fffffffb
1c000008 03 00000007
1c00000c 04 00000002
1c000010 05 fffffff4
1c000014 06 00000001
1c000018 07 00000000
1c00001c 08 ff000000
1c000020 09 01000000
1c000024 0a 00000380
1c000028 0b fffffff0
1c00002c 0c 00000007
1c000030 0d fffffffc
1c000034 0e fffffffd
1c000038 0f 00000f0b
1c00003c 10 00000800
1c000040 11 000007ff
1c000048 12 000007ff

// File: build.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/alu.sv
logic/stage_reg.sv
logic/cpu_core.sv
verif/clk_gen.sv
verif/tb_cpu_core.sv

// File: Makefile
# Verilator simulation of the core testbench

SRCS := $(shell cat build.f)

obj_dir/Vtb_cpu_core: build.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_cpu_core -f build.f

.PHONY: run clean

run: obj_dir/Vtb_cpu_core
	./obj_dir/Vtb_cpu_core | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
